//--- aluArith.sv
`timescale 1ns/100ps

module aluArith
(
	input aluPkg::aluOpcode opcode,
	input aluPkg::aluOperands operands,
	input logic carryIn,
	output aluPkg::aluResult arithResult
);

	import aluPkg::*;

	logic isSubtract;
	logic useCarry;
	logic addCarry;
	logic [dataWidth-1:0] addendB;
	logic [dataWidth:0] sum;
	logic [dataWidth-1:0] sumValue;
	logic carryOut;
	logic overflow;
	logic signedLess;
	logic unsignedLess;
	logic operandsEqual;

	//////////////////////////////////////////////////
	// Shared adder
	//////////////////////////////////////////////////

	assign isSubtract = opcode inside {SUB, SUBI, CMP, CMPI};
	assign useCarry = opcode inside {ADDCU, ADDCUI};

	// Subtract is A plus inverted B plus one
	assign addendB = isSubtract ? ~operands.b : operands.b;
	assign addCarry = isSubtract | (useCarry & carryIn);

	assign sum = {1'b0, operands.a} + {1'b0, addendB} + {{dataWidth{1'b0}}, addCarry};
	assign sumValue = sum[dataWidth-1:0];
	assign carryOut = sum[dataWidth];

	// Like-signed inputs to the adder giving the opposite sign
	assign overflow = (operands.a[dataWidth-1] == addendB[dataWidth-1])
		&& (sumValue[dataWidth-1] != operands.a[dataWidth-1]);

	//////////////////////////////////////////////////
	// Comparisons
	//////////////////////////////////////////////////

	assign signedLess = $signed(operands.a) < $signed(operands.b);
	assign unsignedLess = operands.a < operands.b;
	assign operandsEqual = operands.a == operands.b;

	always_comb
	begin
		arithResult = '0;
		case (opcode)
			ADD, ADDI:
			begin
				arithResult.value = sumValue;
				arithResult.flags.zero = sumValue == '0;
				arithResult.flags.flag = overflow;
				arithResult.flags.low = signedLess;
				arithResult.flags.negative = sumValue[dataWidth-1];
			end
			ADDU, ADDUI:
			begin
				arithResult.value = sumValue;
				arithResult.flags.carry = carryOut;
				arithResult.flags.zero = sumValue == '0;
				arithResult.flags.low = unsignedLess;
			end
			ADDCU, ADDCUI:
			begin
				arithResult.value = sumValue;
				arithResult.flags.carry = carryOut;
				// Wrap to zero with a carry out is not a zero result
				arithResult.flags.zero = (sumValue == '0) && !carryOut;
				arithResult.flags.low = unsignedLess;
			end
			SUB, SUBI:
			begin
				arithResult.value = sumValue;
				arithResult.flags.zero = operandsEqual;
				arithResult.flags.flag = overflow;
				arithResult.flags.low = signedLess;
				arithResult.flags.negative = sumValue[dataWidth-1];
			end
			CMP, CMPI:
			begin
				// Flags only, value stays zero
				arithResult.flags.zero = operandsEqual;
				arithResult.flags.low = unsignedLess;
				arithResult.flags.negative = signedLess;
			end
			default:
			begin
				arithResult = '0;
			end
		endcase
	end

	// Zero from the operand compare must match the subtract result
	always_comb
	begin
		if (opcode inside {SUB, SUBI})
		begin
			assert final (arithResult.flags.zero == (arithResult.value == '0))
				else $error("zero flag disagrees with value for %s", opcode.name());
		end
	end

endmodule

//--- aluExecute.sv
`timescale 1ns/100ps

module aluExecute
(
	input logic clk,
	input logic reset,
	input logic valid,
	input aluPkg::aluOpcode opcode,
	input aluPkg::aluOperands operands,
	output logic done,
	output aluPkg::aluResult result
);

	import aluPkg::*;

	aluResult arithResult;
	aluResult logicResult;
	logic carryIn;

	//////////////////////////////////////////////////
	// Execution units
	//////////////////////////////////////////////////

	// Add, subtract and compare
	aluArith u_aluArith
	(
		.opcode(opcode),
		.operands(operands),
		.carryIn(carryIn),
		.arithResult(arithResult)
	);

	// Bitwise and shifts
	aluLogicShift u_aluLogicShift
	(
		.opcode(opcode),
		.operands(operands),
		.logicResult(logicResult)
	);

	//////////////////////////////////////////////////
	// Result register and flags
	//////////////////////////////////////////////////

	aluStatus u_aluStatus
	(
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.opcode(opcode),
		.arithResult(arithResult),
		.logicResult(logicResult),
		.done(done),
		.result(result),
		.carryIn(carryIn)
	);

endmodule

//--- aluLogicShift.sv
`timescale 1ns/100ps

module aluLogicShift
(
	input aluPkg::aluOpcode opcode,
	input aluPkg::aluOperands operands,
	output aluPkg::aluResult logicResult
);

	import aluPkg::*;

	logic shiftOut;
	logic [shiftWidth-1:0] shiftAmount;
	logic signed [dataWidth-1:0] signedA;
	logic [dataWidth-1:0] leftShifted;
	logic [dataWidth-1:0] rightShifted;
	logic [dataWidth-1:0] arithShifted;
	logic [dataWidth-1:0] inverted;
	logic signedLess;
	logic unsignedLess;

	//////////////////////////////////////////////////
	// Shifter
	//////////////////////////////////////////////////

	// Any set bit above the low shift bits moves the whole word out
	assign shiftOut = |operands.b[dataWidth-1:shiftWidth];
	assign shiftAmount = operands.b[shiftWidth-1:0];
	assign signedA = operands.a;

	assign leftShifted = shiftOut ? '0 : operands.a << shiftAmount;
	assign rightShifted = shiftOut ? '0 : operands.a >> shiftAmount;

	always_comb
	begin
		if (shiftOut)
			arithShifted = {dataWidth{operands.a[dataWidth-1]}};
		else
			arithShifted = signedA >>> shiftAmount;
	end

	assign inverted = ~operands.a;
	assign signedLess = $signed(operands.a) < $signed(operands.b);
	assign unsignedLess = operands.a < operands.b;

	always_comb
	begin
		logicResult = '0;
		case (opcode)
			TEST, AND, OR, XOR:
			begin
				if (opcode == OR)
					logicResult.value = operands.a | operands.b;
				else if (opcode == XOR)
					logicResult.value = operands.a ^ operands.b;
				else
					logicResult.value = operands.a & operands.b;
				logicResult.flags.low = unsignedLess;
				logicResult.flags.negative = signedLess;
				logicResult.flags.zero = logicResult.value == '0;
			end
			NOT:
			begin
				logicResult.value = inverted;
				logicResult.flags.low = inverted < operands.a;
				logicResult.flags.negative = inverted[dataWidth-1];
				logicResult.flags.zero = inverted == '0;
			end
			LSH, LSHI, ALSH:
			begin
				logicResult.value = leftShifted;
				logicResult.flags.zero = leftShifted == '0;
			end
			RSH, RSHI:
			begin
				logicResult.value = rightShifted;
				logicResult.flags.zero = rightShifted == '0;
			end
			ARSH:
			begin
				logicResult.value = arithShifted;
				logicResult.flags.zero = arithShifted == '0;
			end
			default:
			begin
				logicResult = '0;
			end
		endcase
	end

endmodule

//--- aluPkg.sv
package aluPkg;

	// Operand and result width
	localparam int dataWidth = 16;
	localparam int shiftWidth = $clog2(dataWidth);

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	// Any encoding not listed here is undefined
	typedef enum logic [7:0]
	{
		NOP    = 8'h00,
		AND    = 8'h01,
		OR     = 8'h02,
		XOR    = 8'h03,
		NOT    = 8'h04,
		ADD    = 8'h05,
		ADDU   = 8'h06,
		ADDCU  = 8'h07,
		TEST   = 8'h08,
		SUB    = 8'h09,
		CMP    = 8'h0B,
		ADDI   = 8'h50,
		ADDUI  = 8'h60,
		ADDCUI = 8'h70,
		LSHI   = 8'h80,
		RSHI   = 8'h81,
		LSH    = 8'h84,
		ALSH   = 8'h86,
		ARSH   = 8'h87,
		RSH    = 8'h8C,
		SUBI   = 8'h90,
		CMPI   = 8'hB0
	} aluOpcode;

	//////////////////////////////////////////////////
	// Payloads
	//////////////////////////////////////////////////

	typedef struct packed
	{
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
	} aluOperands;

	typedef struct packed
	{
		logic carry;
		logic flag;
		logic low;
		logic negative;
		logic zero;
	} aluFlags;

	typedef struct packed
	{
		logic [dataWidth-1:0] value;
		aluFlags flags;
	} aluResult;

	// Opcodes served by the arithmetic unit
	function automatic logic isArithOp(input aluOpcode op);
		return op inside {ADD, ADDI, ADDU, ADDUI, ADDCU, ADDCUI, SUB, SUBI, CMP, CMPI};
	endfunction

	// NOP and undefined encodings keep the status register
	function automatic logic writesFlags(input aluOpcode op);
		return isArithOp(op) || (op inside {TEST, AND, OR, XOR, NOT, LSH, LSHI,
			RSH, RSHI, ALSH, ARSH});
	endfunction

endpackage

//--- aluStatus.sv
`timescale 1ns/100ps

module aluStatus
(
	input logic clk,
	input logic reset,
	input logic valid,
	input aluPkg::aluOpcode opcode,
	input aluPkg::aluResult arithResult,
	input aluPkg::aluResult logicResult,
	output logic done,
	output aluPkg::aluResult result,
	output logic carryIn
);

	import aluPkg::*;

	logic arithSelected;
	logic flagWrite;
	logic [dataWidth-1:0] nextValue;
	logic [dataWidth-1:0] valueReg;
	aluFlags nextFlags;
	aluFlags flagReg;

	//////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////

	assign arithSelected = isArithOp(opcode);
	assign flagWrite = writesFlags(opcode);

	always_comb
	begin
		if (arithSelected)
		begin
			nextValue = arithResult.value;
			nextFlags = arithResult.flags;
		end
		else
		begin
			// NOP and undefined opcodes return zero
			nextValue = flagWrite ? logicResult.value : '0;
			nextFlags = logicResult.flags;
		end
	end

	//////////////////////////////////////////////////
	// Result and status registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			done <= 1'b0;
			valueReg <= '0;
			flagReg <= '0;
		end
		else
		begin
			done <= valid;
			if (valid)
			begin
				valueReg <= nextValue;
				if (flagWrite)
					flagReg <= nextFlags;
			end
		end
	end

	assign result.value = valueReg;
	assign result.flags = flagReg;

	// Stored carry goes back to the adder for the next issue
	assign carryIn = flagReg.carry;

	// Done is the issue strobe one clock later
	doneAfterIssue: assert property (@(posedge clk) disable iff (reset)
		valid |=> done)
		else $error("done missing after issue");

	noSpuriousDone: assert property (@(posedge clk) disable iff (reset)
		!valid |=> !done)
		else $error("done without issue");

	// Status only moves on a completing operation
	flagsHoldIdle: assert property (@(posedge clk) disable iff (reset)
		!done |-> $stable(flagReg))
		else $error("flags changed without done");

endmodule

//--- filelist.f
+incdir+.
aluPkg.sv
aluArith.sv
aluLogicShift.sv
aluStatus.sv
aluExecute.sv
tbAluExecute.sv

//--- tbAluModel.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

//////////////////////////////////////////////////
// Reference model of the execute stage
//////////////////////////////////////////////////

// Next result and status; prev is the status before the operation
function automatic aluResult modelOperation(input aluOpcode op,
	input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b, input aluFlags prev);
	aluResult r;
	int sa;
	int sb;
	int wide;
	int amount;
	r = '0;
	sa = $signed(a);
	sb = $signed(b);
	// Anything past the word width empties it
	amount = (b > dataWidth) ? dataWidth : b;
	case (op)
		ADD, ADDI, SUB, SUBI:
		begin
			wide = (op inside {SUB, SUBI}) ? sa - sb : sa + sb;
			r.value = wide[dataWidth-1:0];
			// Exact sum that does not fit back into 16 signed bits
			r.flags.flag = wide != $signed(r.value);
			r.flags.low = sa < sb;
			r.flags.negative = r.value[dataWidth-1];
			r.flags.zero = (op inside {SUB, SUBI}) ? a == b : r.value == '0;
		end
		ADDU, ADDUI, ADDCU, ADDCUI:
		begin
			wide = int'(a) + int'(b) + ((op inside {ADDCU, ADDCUI}) ? prev.carry : 0);
			r.value = wide[dataWidth-1:0];
			r.flags.carry = (wide >> dataWidth) != 0;
			r.flags.low = a < b;
			r.flags.zero = (op inside {ADDCU, ADDCUI}) ? wide == 0 : r.value == '0;
		end
		CMP, CMPI:
		begin
			r.flags.low = a < b;
			r.flags.negative = sa < sb;
			r.flags.zero = a == b;
		end
		TEST, AND, OR, XOR:
		begin
			r.value = (op == OR) ? a | b : (op == XOR) ? a ^ b : a & b;
			r.flags.low = a < b;
			r.flags.negative = sa < sb;
			r.flags.zero = r.value == '0;
		end
		NOT:
		begin
			r.value = ~a;
			r.flags.low = r.value < a;
			r.flags.negative = r.value[dataWidth-1];
			r.flags.zero = r.value == '0;
		end
		LSH, LSHI, ALSH, RSH, RSHI, ARSH:
		begin
			// One bit position per step
			r.value = a;
			repeat (amount)
			begin
				if (op inside {RSH, RSHI})
					r.value = {1'b0, r.value[dataWidth-1:1]};
				else if (op == ARSH)
					r.value = {a[dataWidth-1], r.value[dataWidth-1:1]};
				else
					r.value = {r.value[dataWidth-2:0], 1'b0};
			end
			r.flags.zero = r.value == '0;
		end
		default:
		begin
			// NOP and undefined, zero value and status kept
			r.flags = prev;
		end
	endcase
	return r;
endfunction

`endif

//--- tbAluExecute.sv
`timescale 1ns/100ps

module tbAluExecute;

	import aluPkg::*;

	`include "tbAluModel.svh"

	// Reset plus about 2600 cycles of tests, with headroom
	localparam int cycleLimit = 4000;
	localparam int randomCount = 500;

	logic clk;
	logic reset;
	logic valid;
	aluOpcode opcode;
	aluOperands operands;
	logic done;
	aluResult result;

	integer seed = 20;
	int errorCount = 0;
	int cycleCount = 0;
	int issueCount = 0;
	int totalIssues = 0;
	int testsRun = 0;
	int testStartErrors = 0;
	logic sampledValid = 1'b0;
	aluFlags modelFlags = '0;
	aluResult lastResult = '0;
	aluOpcode lastOp = NOP;
	aluResult expectedQueue[$];
	aluOpcode opQueue[$];
	aluOpcode arithOps[6] = '{ADD, ADDI, ADDU, ADDUI, SUB, SUBI};
	aluOpcode logicOps[7] = '{CMP, CMPI, TEST, AND, OR, XOR, NOT};
	aluOpcode shiftOps[6] = '{LSH, LSHI, ALSH, RSH, RSHI, ARSH};
	logic [dataWidth-1:0] extremes[4] = '{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF};

	aluExecute u_aluExecute
	(
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.opcode(opcode),
		.operands(operands),
		.done(done),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////

	task automatic reportError(input string message);
		$display("ERR %0t: %s", $time, message);
		errorCount++;
	endtask

	// Issue strobe as the DUT samples it
	always @(posedge clk)
		sampledValid <= valid && !reset;

	// Outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (done === sampledValid)
				else reportError($sformatf("done is %b, expected %b", done, sampledValid));
			if (sampledValid)
			begin
				assert (expectedQueue.size() != 0)
				else
				begin
					$display("Scoreboard problem: done came with no operation queued");
					errorCount++;
				end
				if (expectedQueue.size() != 0)
				begin
					lastResult = expectedQueue.pop_front();
					lastOp = opQueue.pop_front();
				end
			end
			assert (result.value === lastResult.value)
				else reportError($sformatf("opcode %h value is %h, expected %h", lastOp,
					result.value, lastResult.value));
			assert (result.flags === lastResult.flags)
				else reportError($sformatf("opcode %h flags cflnz are %b, expected %b", lastOp,
					result.flags, lastResult.flags));
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic driveCycle(input logic doIssue, input aluOpcode op,
		input logic [dataWidth-1:0] opA, input logic [dataWidth-1:0] opB);
		aluResult expected;
		@(posedge clk);
		valid <= doIssue;
		opcode <= op;
		operands <= {opA, opB};
		if (doIssue)
		begin
			expected = modelOperation(op, opA, opB, modelFlags);
			modelFlags = expected.flags;
			expectedQueue.push_back(expected);
			opQueue.push_back(op);
			issueCount++;
			totalIssues++;
		end
	endtask

	task automatic finishTest(input string testName);
		@(posedge clk);
		valid <= 1'b0;
		while (expectedQueue.size() != 0)
			@(posedge clk);
		$display("Test %s: %0d issues, %0d errors", testName, issueCount,
			errorCount - testStartErrors);
		testsRun++;
		issueCount = 0;
		testStartErrors = errorCount;
	endtask

	function automatic logic [dataWidth-1:0] pickOperand();
		if (($random(seed) & 3) == 0)
			return extremes[$unsigned($random(seed)) % 4];
		return 16'($random(seed));
	endfunction

	function automatic logic [dataWidth-1:0] pickShiftAmount();
		case ($unsigned($random(seed)) % 5)
			0: return 16'd0;
			1: return 16'd15;
			2: return 16'd16 + 16'($unsigned($random(seed)) % 48);
			3: return 16'($unsigned($random(seed)) % 16);
			default: return 16'($random(seed));
		endcase
	endfunction

	function automatic aluOpcode pickOpcode(input int group);
		case (group)
			0: return arithOps[$unsigned($random(seed)) % 6];
			1: return logicOps[$unsigned($random(seed)) % 7];
			default: return shiftOps[$unsigned($random(seed)) % 6];
		endcase
	endfunction

	// Three in four cycles issue, idle cycles carry junk opcodes
	task automatic runRandomOps(input string testName, input int group);
		logic [dataWidth-1:0] opB;
		while (issueCount < randomCount)
		begin
			if (($random(seed) & 3) != 0)
			begin
				opB = (group == 2) ? pickShiftAmount() : pickOperand();
				driveCycle(1'b1, pickOpcode(group), pickOperand(), opB);
			end
			else
				driveCycle(1'b0, aluOpcode'(8'($random(seed))), pickOperand(), pickOperand());
		end
		finishTest(testName);
	endtask

	task automatic runCarryChains();
		// Carry out on a zero sum, then zero sums with and without stored carry
		driveCycle(1'b1, ADDU, 16'hFFFF, 16'h0001);
		driveCycle(1'b1, ADDCU, 16'hFFFF, 16'h0000);
		driveCycle(1'b1, ADDU, 16'h0000, 16'h0000);
		driveCycle(1'b1, ADDCUI, 16'h0000, 16'h0000);
		repeat (100)
		begin
			driveCycle(1'b1, ADDU, pickOperand() | 16'h8000, pickOperand());
			driveCycle(1'b1, (($random(seed) & 1) != 0) ? ADDCUI : ADDCU, pickOperand(),
				pickOperand());
			if (($random(seed) & 1) != 0)
				driveCycle(1'b0, NOP, 16'h0000, 16'h0000);
		end
		finishTest("carry chains");
	endtask

	task automatic runNopMix();
		repeat (100)
		begin
			driveCycle(1'b1, pickOpcode($unsigned($random(seed)) % 3), pickOperand(),
				pickOperand());
			// 8'hC0 and up holds no defined opcode
			repeat (1 + $unsigned($random(seed)) % 3)
				driveCycle(1'b1, (($random(seed) & 1) != 0) ? NOP
					: aluOpcode'(8'hC0 | 8'($random(seed))), pickOperand(), pickOperand());
		end
		finishTest("nop and undefined");
	endtask

	initial
	begin
		reset = 1'b1;
		valid = 1'b0;
		opcode = NOP;
		operands = '0;
		repeat (16)
			@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (done === 1'b0 && result === '0)
			else reportError($sformatf("after reset done %b value %h flags %b", done,
				result.value, result.flags));
		finishTest("reset state");
		runRandomOps("add and subtract", 0);
		runCarryChains();
		runRandomOps("compare and logic", 1);
		runRandomOps("shifts", 2);
		runNopMix();
		$display("Tests %0d, issues %0d, failed checks %0d", testsRun, totalIssues, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
